/* rtl/switch_pkg.sv */
`default_nettype none

package switch_pkg;

	// Switch sizes
	localparam int NETH = 4;
	localparam int DATAW = 64;
	localparam int MACW = 48;
	localparam int LGTBL = 3;
	localparam int NTBL = 1 << LGTBL;

	// Header layout, beat 0 holds the destination on top
	localparam int DST_MAC_MSB = 63;
	// Upper source MAC bits sit at the bottom of beat 0
	localparam int SRC_HI_W = 16;

	typedef logic [$clog2(NETH)-1:0] port_idx_t;
	typedef logic [NETH-1:0] port_mask_t;
	typedef logic [MACW-1:0] mac_t;

	// One stream beat, always a full word
	typedef struct packed {
		logic [DATAW-1:0] data;
		logic last;
	} beat_t;

	// Source address and the port it came in on
	typedef struct packed {
		mac_t mac;
		port_idx_t port;
	} learn_t;

	// Round-robin choice, first requester after the last winner
	function automatic port_idx_t rr_pick(input port_mask_t req, input port_idx_t last);
		port_idx_t pick;
		port_idx_t cand;
		pick = last;
		// Walk from farthest to nearest so the nearest requester wins
		for (int i = NETH; i >= 1; i--)
		begin
			cand = last + port_idx_t'(i);
			if (req[cand])
				pick = cand;
		end
		return pick;
	endfunction

endpackage

`default_nettype wire

/* rtl/rx_mac_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_mac_parser (
	input  wire                     i_clk,
	input  wire                     i_arst_n,
	input  wire switch_pkg::port_idx_t i_port,
	input  wire                     i_valid,
	output logic                    o_ready,
	input  wire switch_pkg::beat_t  i_beat,
	output logic                    o_valid,
	input  wire                     i_ready,
	output switch_pkg::beat_t       o_beat,
	output logic                    o_learn_valid,
	input  wire                     i_learn_ready,
	output switch_pkg::learn_t      o_learn
);
	import switch_pkg::*;

	// Position in packet: 0 header, 1 second beat, 2 anything later
	logic [1:0] beat_cnt;
	logic [SRC_HI_W-1:0] src_hi;
	logic in_fire;

	// Output register free or draining, and no learn still waiting
	assign o_ready = (!o_valid || i_ready) && !o_learn_valid;
	assign in_fire = i_valid && o_ready;

	//////////////////////////////
	// Control state
	//////////////////////////////
	always_ff @(posedge i_clk or negedge i_arst_n)
		if (!i_arst_n)
		begin
			beat_cnt <= '0;
			o_valid <= 1'b0;
			o_learn_valid <= 1'b0;
		end
		else
		begin
			// Beat counter restarts after each last beat
			if (in_fire)
			begin
				if (i_beat.last)
					beat_cnt <= '0;
				else if (beat_cnt != 2'd2)
					beat_cnt <= beat_cnt + 2'd1;
			end

			// Single output stage
			if (in_fire)
				o_valid <= 1'b1;
			else if (i_ready)
				o_valid <= 1'b0;

			// Learn request raised with beat 1, held until taken
			if (in_fire && beat_cnt == 2'd1)
				o_learn_valid <= 1'b1;
			else if (i_learn_ready)
				o_learn_valid <= 1'b0;
		end

	//////////////////////////////
	// Payload
	//////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (in_fire)
			o_beat <= i_beat;
		// Keep the upper source bits from the header beat
		if (in_fire && beat_cnt == 2'd0)
			src_hi <= i_beat.data[SRC_HI_W-1:0];
		// Lower source bits complete the record on beat 1
		if (in_fire && beat_cnt == 2'd1)
		begin
			o_learn.mac <= {src_hi, i_beat.data[DATAW-1 -: MACW-SRC_HI_W]};
			o_learn.port <= i_port;
		end
	end

endmodule

`default_nettype wire

/* rtl/route_table.sv */
`timescale 1ns/1ps
`default_nettype none

module route_table (
	input  wire                          i_clk,
	input  wire                          i_arst_n,
	input  wire switch_pkg::port_mask_t  i_learn_valid,
	output switch_pkg::port_mask_t       o_learn_ready,
	input  wire switch_pkg::learn_t      i_learn [switch_pkg::NETH],
	input  wire switch_pkg::port_mask_t  i_lkup_req,
	output switch_pkg::port_mask_t       o_lkup_grant,
	input  wire switch_pkg::mac_t        i_lkup_mac [switch_pkg::NETH],
	output switch_pkg::port_mask_t       o_lkup_ack,
	output switch_pkg::port_mask_t       o_lkup_mask [switch_pkg::NETH]
);
	import switch_pkg::*;

	// Table storage, one MAC and port per entry
	learn_t tbl [NTBL];
	logic [NTBL-1:0] tbl_vld;
	// Next entry to overwrite on a learn miss
	logic [LGTBL-1:0] rptr;

	port_idx_t ln_idx;
	learn_t ln_rec;
	logic ln_hit;
	logic [LGTBL-1:0] ln_hidx;

	port_idx_t lk_last;
	port_idx_t lk_idx;
	port_mask_t lk_result;

	//////////////////////////////
	// Learn side
	//////////////////////////////

	// Lowest requesting port wins, isolate its bit
	assign o_learn_ready = i_learn_valid & (~i_learn_valid + port_mask_t'(1));

	always_comb
	begin
		ln_idx = '0;
		for (int p = NETH - 1; p >= 0; p--)
			if (i_learn_valid[p])
				ln_idx = port_idx_t'(p);
	end

	assign ln_rec = i_learn[ln_idx];

	// Look for the source address already present
	always_comb
	begin
		ln_hit = 1'b0;
		ln_hidx = '0;
		for (int e = 0; e < NTBL; e++)
			if (tbl_vld[e] && tbl[e].mac == ln_rec.mac)
			begin
				ln_hit = 1'b1;
				ln_hidx = LGTBL'(e);
			end
	end

	always_ff @(posedge i_clk or negedge i_arst_n)
		if (!i_arst_n)
		begin
			tbl_vld <= '0;
			rptr <= '0;
		end
		else if (|i_learn_valid && !ln_hit)
		begin
			// Miss takes the entry at the pointer, wraps at the end
			tbl_vld[rptr] <= 1'b1;
			rptr <= rptr + 1'b1;
		end

	always_ff @(posedge i_clk)
		if (|i_learn_valid)
		begin
			// Known address moves to its new port in place
			if (ln_hit)
				tbl[ln_hidx].port <= ln_rec.port;
			else
				tbl[rptr] <= ln_rec;
		end

	//////////////////////////////
	// Lookup side
	//////////////////////////////
	assign lk_idx = rr_pick(i_lkup_req, lk_last);
	assign o_lkup_grant = (|i_lkup_req) ? (port_mask_t'(1) << lk_idx) : '0;

	// Miss floods, hit returns the stored port only
	// Reads the table as it stands before this cycle's learn write
	always_comb
	begin
		lk_result = '1;
		for (int e = 0; e < NTBL; e++)
			if (tbl_vld[e] && tbl[e].mac == i_lkup_mac[lk_idx])
				lk_result = port_mask_t'(1) << tbl[e].port;
	end

	always_ff @(posedge i_clk or negedge i_arst_n)
		if (!i_arst_n)
		begin
			o_lkup_ack <= '0;
			lk_last <= '0;
		end
		else
		begin
			// Answer one cycle after the grant
			o_lkup_ack <= o_lkup_grant;
			if (|i_lkup_req)
				lk_last <= lk_idx;
		end

	always_ff @(posedge i_clk)
		if (|i_lkup_req)
			o_lkup_mask[lk_idx] <= lk_result;

endmodule

`default_nettype wire

/* rtl/tx_port_select.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_port_select (
	input  wire                         i_clk,
	input  wire                         i_arst_n,
	input  wire switch_pkg::port_idx_t  i_port,
	input  wire                         i_valid,
	output logic                        o_ready,
	input  wire switch_pkg::beat_t      i_beat,
	output logic                        o_lkup_req,
	input  wire                         i_lkup_grant,
	output switch_pkg::mac_t            o_lkup_mac,
	input  wire                         i_lkup_ack,
	input  wire switch_pkg::port_mask_t i_lkup_mask,
	output logic                        o_valid,
	input  wire                         i_ready,
	output switch_pkg::beat_t           o_beat,
	output switch_pkg::port_mask_t      o_mask
);
	import switch_pkg::*;

	typedef enum logic [1:0] {S_HDR, S_LKUP, S_STREAM} sel_state_t;

	sel_state_t state;
	beat_t hold_beat;
	// Held header still to be sent
	logic hold_pend;
	logic discard;
	logic req_pend;
	port_mask_t own_mask;
	port_mask_t fwd_mask;
	logic in_fire;
	logic out_fire;

	// Never send a packet back where it came from
	assign own_mask = port_mask_t'(1) << i_port;
	assign fwd_mask = i_lkup_mask & ~own_mask;

	assign o_lkup_req = req_pend;
	assign o_lkup_mac = hold_beat.data[DST_MAC_MSB -: MACW];

	// Header first, then the input passes straight through
	assign o_beat = hold_pend ? hold_beat : i_beat;
	assign o_valid = (state == S_STREAM) && !discard && (hold_pend || i_valid);
	assign o_ready = (state == S_HDR)
		|| ((state == S_STREAM) && !hold_pend && (discard || i_ready));

	assign in_fire = i_valid && o_ready;
	assign out_fire = o_valid && i_ready;

	always_ff @(posedge i_clk or negedge i_arst_n)
		if (!i_arst_n)
		begin
			state <= S_HDR;
			req_pend <= 1'b0;
			hold_pend <= 1'b0;
			discard <= 1'b0;
		end
		else
			case (state)
				S_HDR:
					if (in_fire)
					begin
						state <= S_LKUP;
						req_pend <= 1'b1;
					end
				S_LKUP:
				begin
					// Request drops once the table takes it
					if (i_lkup_grant)
						req_pend <= 1'b0;
					if (i_lkup_ack)
					begin
						// Empty mask means drop the whole packet
						discard <= (fwd_mask == '0);
						hold_pend <= (fwd_mask != '0);
						if (fwd_mask == '0 && hold_beat.last)
							state <= S_HDR;
						else
							state <= S_STREAM;
					end
				end
				default:
				begin
					if (out_fire && hold_pend)
					begin
						hold_pend <= 1'b0;
						if (hold_beat.last)
							state <= S_HDR;
					end
					if (in_fire && i_beat.last)
						state <= S_HDR;
				end
			endcase

	// Header beat and packet mask
	always_ff @(posedge i_clk)
	begin
		if (state == S_HDR && in_fire)
			hold_beat <= i_beat;
		if (state == S_LKUP && i_lkup_ack)
			o_mask <= fwd_mask;
	end

endmodule

`default_nettype wire

/* rtl/pkt_fanout.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_fanout (
	input  wire                         i_clk,
	input  wire                         i_arst_n,
	input  wire                         i_valid,
	output logic                        o_ready,
	input  wire switch_pkg::beat_t      i_beat,
	input  wire switch_pkg::port_mask_t i_mask,
	output switch_pkg::port_mask_t      o_valid,
	input  wire switch_pkg::port_mask_t i_ready,
	output switch_pkg::beat_t           o_beat
);
	import switch_pkg::*;

	// Outputs that already took the current beat
	port_mask_t done;
	port_mask_t taken;

	assign o_beat = i_beat;
	assign o_valid = {NETH{i_valid}} & i_mask & ~done;
	assign taken = o_valid & i_ready;

	// Beat leaves the input once every target has it
	assign o_ready = &(done | taken | ~i_mask);

	always_ff @(posedge i_clk or negedge i_arst_n)
		if (!i_arst_n)
			done <= '0;
		else if (i_valid && o_ready)
			done <= '0;
		else
			done <= done | taken;

endmodule

`default_nettype wire

/* rtl/pkt_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_arbiter (
	input  wire                         i_clk,
	input  wire                         i_arst_n,
	input  wire switch_pkg::port_mask_t i_valid,
	output switch_pkg::port_mask_t      o_ready,
	input  wire switch_pkg::beat_t      i_beat [switch_pkg::NETH],
	output logic                        o_valid,
	input  wire                         i_ready,
	output switch_pkg::beat_t           o_beat
);
	import switch_pkg::*;

	// Current or most recent winner
	port_idx_t owner;
	port_idx_t pick;
	port_idx_t sel;
	// Held from the first offered beat to the last transfer
	logic locked;

	assign pick = rr_pick(i_valid, owner);
	assign sel = locked ? owner : pick;

	//////////////////////////////
	// Output mux
	//////////////////////////////
	assign o_valid = i_valid[sel];
	assign o_beat = i_beat[sel];
	assign o_ready = i_ready ? (port_mask_t'(1) << sel) : '0;

	//////////////////////////////
	// Grant lock
	//////////////////////////////
	always_ff @(posedge i_clk or negedge i_arst_n)
		if (!i_arst_n)
		begin
			owner <= '0;
			locked <= 1'b0;
		end
		else if (o_valid)
		begin
			// Freeze the choice while a beat waits on ready
			owner <= sel;
			// Release only when the last beat goes out
			locked <= !(i_ready && o_beat.last);
		end

endmodule

`default_nettype wire

/* rtl/eth_switch.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_switch (
	input  wire                         i_clk,
	input  wire                         i_arst_n,
	input  wire switch_pkg::port_mask_t i_rx_valid,
	output wire switch_pkg::port_mask_t o_rx_ready,
	input  wire switch_pkg::beat_t      i_rx_beat [switch_pkg::NETH],
	output wire switch_pkg::port_mask_t o_tx_valid,
	input  wire switch_pkg::port_mask_t i_tx_ready,
	output wire switch_pkg::beat_t      o_tx_beat [switch_pkg::NETH]
);
	import switch_pkg::*;

	// Parser to port select
	wire port_mask_t prs_valid;
	wire port_mask_t prs_ready;
	wire beat_t prs_beat [NETH];

	// Learn and lookup traffic to the shared table
	wire port_mask_t learn_valid;
	wire port_mask_t learn_ready;
	wire learn_t learn [NETH];
	wire port_mask_t lkup_req;
	wire port_mask_t lkup_grant;
	wire port_mask_t lkup_ack;
	wire mac_t lkup_mac [NETH];
	wire port_mask_t lkup_mask [NETH];

	// Tagged packets into the fanout
	wire port_mask_t sel_valid;
	wire port_mask_t sel_ready;
	wire beat_t sel_beat [NETH];
	wire port_mask_t sel_mask [NETH];

	// Fanout rows indexed by input, arbiter columns by output
	wire port_mask_t fan_valid [NETH];
	wire port_mask_t fan_ready [NETH];
	wire beat_t fan_beat [NETH];
	wire port_mask_t arb_valid [NETH];
	wire port_mask_t arb_ready [NETH];
	wire beat_t arb_beat [NETH][NETH];

	//////////////////////////////
	// Per-port receive paths
	//////////////////////////////
	for (genvar gp = 0; gp < NETH; gp++)
	begin : g_port
		rx_mac_parser rx_mac_parser_inst (
			.i_clk(i_clk), .i_arst_n(i_arst_n), .i_port(port_idx_t'(gp)),
			.i_valid(i_rx_valid[gp]), .o_ready(o_rx_ready[gp]), .i_beat(i_rx_beat[gp]),
			.o_valid(prs_valid[gp]), .i_ready(prs_ready[gp]), .o_beat(prs_beat[gp]),
			.o_learn_valid(learn_valid[gp]), .i_learn_ready(learn_ready[gp]),
			.o_learn(learn[gp])
		);

		tx_port_select tx_port_select_inst (
			.i_clk(i_clk), .i_arst_n(i_arst_n), .i_port(port_idx_t'(gp)),
			.i_valid(prs_valid[gp]), .o_ready(prs_ready[gp]), .i_beat(prs_beat[gp]),
			.o_lkup_req(lkup_req[gp]), .i_lkup_grant(lkup_grant[gp]),
			.o_lkup_mac(lkup_mac[gp]), .i_lkup_ack(lkup_ack[gp]),
			.i_lkup_mask(lkup_mask[gp]),
			.o_valid(sel_valid[gp]), .i_ready(sel_ready[gp]), .o_beat(sel_beat[gp]),
			.o_mask(sel_mask[gp])
		);

		pkt_fanout pkt_fanout_inst (
			.i_clk(i_clk), .i_arst_n(i_arst_n),
			.i_valid(sel_valid[gp]), .o_ready(sel_ready[gp]), .i_beat(sel_beat[gp]),
			.i_mask(sel_mask[gp]),
			.o_valid(fan_valid[gp]), .i_ready(fan_ready[gp]), .o_beat(fan_beat[gp])
		);

		// Row gp of the crossbar feeds column gp of every arbiter
		for (genvar gm = 0; gm < NETH; gm++)
		begin : g_xbar
			assign arb_valid[gm][gp] = fan_valid[gp][gm];
			assign arb_beat[gm][gp] = fan_beat[gp];
			assign fan_ready[gp][gm] = arb_ready[gm][gp];
		end

		pkt_arbiter pkt_arbiter_inst (
			.i_clk(i_clk), .i_arst_n(i_arst_n),
			.i_valid(arb_valid[gp]), .o_ready(arb_ready[gp]), .i_beat(arb_beat[gp]),
			.o_valid(o_tx_valid[gp]), .i_ready(i_tx_ready[gp]), .o_beat(o_tx_beat[gp])
		);
	end

	//////////////////////////////
	// Shared route table
	//////////////////////////////
	route_table route_table_inst (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_learn_valid(learn_valid), .o_learn_ready(learn_ready), .i_learn(learn),
		.i_lkup_req(lkup_req), .o_lkup_grant(lkup_grant), .i_lkup_mac(lkup_mac),
		.o_lkup_ack(lkup_ack), .o_lkup_mask(lkup_mask)
	);

endmodule

`default_nettype wire

/* test/switch_model.svh */
// Packet as an ordered list of beats
typedef beat_t pkt_q_t [$];

// Mirror of the route table
mac_t m_mac [NTBL];
port_idx_t m_port [NTBL];
logic [NTBL-1:0] m_vld = '0;
int unsigned m_rptr = 0;

// Expected beats indexed by output then by source port
beat_t exp_q [NETH][NETH][$];
int unsigned beats_sent = 0;
string test_name = "reset";

task automatic stop_with_error(input string why);
	$display("%s", why);
	$display("Finished with errors");
	$fatal(1, "simulation stopped on the first error");
endtask

task automatic check_val(input string what, input logic [DATAW:0] exp, input logic [DATAW:0] act);
	if (exp !== act)
		stop_with_error($sformatf("mismatch %s %s expected %h actual %h",
			test_name, what, exp, act));
endtask

// Header fields by the package layout
function automatic mac_t dst_of(input pkt_q_t pkt);
	return pkt[0].data[DST_MAC_MSB -: MACW];
endfunction

function automatic mac_t src_of(input pkt_q_t pkt);
	return {pkt[0].data[SRC_HI_W-1:0], pkt[1].data[DATAW-1 -: MACW-SRC_HI_W]};
endfunction

function automatic pkt_q_t build_pkt(input mac_t dst, input mac_t src, input int n);
	pkt_q_t pkt;
	beat_t b;
	for (int i = 0; i < n; i++)
	begin
		b.data = {$urandom, $urandom};
		b.last = (i == n - 1);
		if (i == 0)
		begin
			b.data[DST_MAC_MSB -: MACW] = dst;
			b.data[SRC_HI_W-1:0] = src[MACW-1 -: SRC_HI_W];
		end
		// Rest of the source fills the top of beat 1
		if (i == 1)
			b.data[DATAW-1 -: MACW-SRC_HI_W] = src[MACW-SRC_HI_W-1:0];
		pkt.push_back(b);
	end
	return pkt;
endfunction

// Unknown destination floods
function automatic port_mask_t lookup_mask(input mac_t dst);
	port_mask_t res;
	res = '1;
	for (int e = 0; e < NTBL; e++)
		if (m_vld[e] && m_mac[e] == dst)
			res = port_mask_t'(1) << m_port[e];
	return res;
endfunction

task automatic learn_mac(input mac_t src, input port_idx_t p);
	int hit;
	hit = -1;
	for (int e = 0; e < NTBL; e++)
		if (m_vld[e] && m_mac[e] == src)
			hit = e;
	if (hit >= 0)
		m_port[hit] = p;
	else
	begin
		// New address goes where the pointer is
		m_vld[m_rptr] = 1'b1;
		m_mac[m_rptr] = src;
		m_port[m_rptr] = p;
		m_rptr = (m_rptr + 1) % NTBL;
	end
endtask

// Lookup sees the table before this packet's own learn
task automatic expect_pkt(input int sp, input pkt_q_t pkt);
	port_mask_t mask;
	mask = lookup_mask(dst_of(pkt)) & ~(port_mask_t'(1) << sp);
	for (int o = 0; o < NETH; o++)
		if (mask[o])
			foreach (pkt[i])
				exp_q[o][sp].push_back(pkt[i]);
	learn_mac(src_of(pkt), port_idx_t'(sp));
endtask

function automatic int pending_beats();
	int n;
	n = 0;
	for (int o = 0; o < NETH; o++)
		for (int s = 0; s < NETH; s++)
			n += exp_q[o][s].size();
	return n;
endfunction

// True when the next packet expected from s on output o has this source
function automatic bit head_from(input int o, input int s, input mac_t src);
	if (exp_q[o][s].size() < 2)
		return 1'b0;
	return {exp_q[o][s][0].data[SRC_HI_W-1:0],
		exp_q[o][s][1].data[DATAW-1 -: MACW-SRC_HI_W]} == src;
endfunction

/* test/eth_switch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_switch_tb;
	import switch_pkg::*;

	logic clk = 1'b0;
	logic arst_n = 1'b0;
	port_mask_t rx_valid = '0;
	port_mask_t rx_ready;
	beat_t rx_beat [NETH];
	port_mask_t tx_valid;
	port_mask_t tx_ready = '1;
	beat_t tx_beat [NETH];
	// Random ready on one output while set
	logic bp_en = 1'b0;
	port_idx_t bp_port = '0;
	// Station address owned by each port
	mac_t port_mac [NETH];
	int unsigned cycles = 0;

	`include "switch_model.svh"

	eth_switch eth_switch_inst (
		.i_clk(clk), .i_arst_n(arst_n),
		.i_rx_valid(rx_valid), .o_rx_ready(rx_ready), .i_rx_beat(rx_beat),
		.o_tx_valid(tx_valid), .i_tx_ready(tx_ready), .o_tx_beat(tx_beat)
	);

	always #2 clk = ~clk;

	// Back-pressure on the selected output
	always @(negedge clk)
		if (bp_en)
			tx_ready[bp_port] = ($urandom % 2) == 1;
		else
			tx_ready = '1;

	// Budget grows with every beat sent
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > 200 + 24 * beats_sent)
			stop_with_error($sformatf("Timeout, packets stopped moving after %0d cycles",
				cycles));
	end

	//////////////////////////////
	// Stream driver and monitor
	//////////////////////////////
	task automatic send_pkt(input int p, input pkt_q_t pkt);
		expect_pkt(p, pkt);
		beats_sent += pkt.size();
		foreach (pkt[i])
		begin
			@(negedge clk);
			rx_valid[p] = 1'b1;
			rx_beat[p] = pkt[i];
			@(posedge clk);
			while (!rx_ready[p])
				@(posedge clk);
		end
		@(negedge clk);
		rx_valid[p] = 1'b0;
	endtask

	task automatic wait_drained();
		while (pending_beats() != 0)
			@(posedge clk);
	endtask

	function automatic int rand_len();
		return 2 + int'($urandom % 5);
	endfunction

	// One packet alone in the switch
	task automatic send_one(input int p, input mac_t dst, input mac_t src);
		send_pkt(p, build_pkt(dst, src, rand_len()));
		wait_drained();
	endtask

	task automatic send_burst(input int p, input int n);
		repeat (n)
			send_pkt(p, build_pkt(port_mac[0], port_mac[p], rand_len()));
	endtask

	task automatic compare_pkt(input int o, input int s, input pkt_q_t got);
		foreach (got[i])
			if (exp_q[o][s].size() == 0)
				stop_with_error($sformatf("Output %0d sent more beats than expected", o));
			else
				check_val($sformatf("out%0d src%0d beat%0d", o, s, i),
					exp_q[o][s].pop_front(), got[i]);
	endtask

	task automatic collect_output(input int o);
		pkt_q_t rx;
		pkt_q_t got;
		int s;
		forever
		begin
			@(posedge clk);
			if (tx_valid[o] && tx_ready[o])
			begin
				rx.push_back(tx_beat[o]);
				if (tx_beat[o].last)
				begin
					got = rx;
					rx.delete();
					s = -1;
					// Match by source MAC against each queue head
					for (int c = 0; c < NETH; c++)
						if (s < 0 && got.size() >= 2 && head_from(o, c, src_of(got)))
							s = c;
					if (s < 0)
						stop_with_error($sformatf("Output %0d sent a packet nobody expected",
							o));
					else
						compare_pkt(o, s, got);
				end
			end
		end
	endtask

	for (genvar go = 0; go < NETH; go++)
	begin : g_mon
		initial collect_output(go);
	end

	//////////////////////////////
	// Behavior sequence
	//////////////////////////////
	initial
	begin
		mac_t dst;
		void'($urandom(32'h3262));
		foreach (rx_beat[p])
		begin
			rx_beat[p] = '0;
			port_mac[p] = {32'h0200_1000, 16'(p + 1)};
		end
		repeat (4) @(negedge clk);
		arst_n = 1'b1;
		repeat (2) @(negedge clk);

		// Empty table so everything floods
		test_name = "flood";
		for (int p = 0; p < NETH; p++)
			send_one(p, 48'hffff_ffff_ffff, port_mac[p]);

		test_name = "unicast";
		send_one(0, port_mac[2], port_mac[0]);

		test_name = "own_discard";
		send_one(1, port_mac[1], port_mac[1]);

		// Twelve new sources wrap the pointer past the real stations
		test_name = "replace";
		for (int k = 0; k < 12; k++)
		begin
			if (k > 0 && $urandom % 2 == 1)
				dst = {32'h0200_a000, 16'($urandom % k)};
			else
				dst = port_mac[$urandom % NETH];
			send_one(k % NETH, dst, {32'h0200_a000, 16'(k)});
		end
		for (int k = 0; k < 12; k++)
			send_one(3, {32'h0200_a000, 16'(k)}, port_mac[3]);
		for (int p = 0; p < 3; p++)
			send_one(3, port_mac[p], port_mac[3]);

		// Relearn the stations so the burst stays unicast
		test_name = "arbitration";
		for (int p = 0; p < NETH; p++)
			send_one(p, 48'hffff_ffff_ffff, port_mac[p]);
		bp_port = 0;
		bp_en = 1'b1;
		fork
			send_burst(1, 4);
			send_burst(2, 4);
			send_burst(3, 4);
		join
		wait_drained();
		bp_en = 1'b0;
		repeat (20) @(negedge clk);

		// Idle switch shows no output beat and takes input on every port
		if (pending_beats() != 0 || tx_valid != '0 || rx_ready != '1)
			stop_with_error("The switch did not return to idle after the last packet");
		else
		begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* eth_switch.f */
+incdir+test
rtl/switch_pkg.sv
rtl/rx_mac_parser.sv
rtl/route_table.sv
rtl/tx_port_select.sv
rtl/pkt_fanout.sv
rtl/pkt_arbiter.sv
rtl/eth_switch.sv
test/eth_switch_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = eth_switch_tb
FLIST     = eth_switch.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
